//--- hw/tile_pkg.sv
// Tile memory glue definitions
// Bus widths, walker and data-cache operation codes, requester ids,
// the data-cache request layout and the PMU event map
package tile_pkg;

    localparam int addr_w       = 40;
    localparam int data_w       = 64;
    localparam int be_w         = data_w / 8;
    localparam int size_w       = 3;
    localparam int sid_w        = 1;
    localparam int line_w       = 256;
    localparam int beat_w       = 2;
    localparam int inval_addr_w = 12;
    localparam int cnt_w        = 32;

    // Walker command encoding
    // Atomic OR sets the accessed and dirty bits
    typedef logic [4:0] ptw_cmd_t;
    localparam ptw_cmd_t ptw_cmd_amo_or = 5'b01010;

    typedef enum logic [1:0] {
        dmem_op_load   = 2'd0,
        dmem_op_store  = 2'd1,
        dmem_op_amo_or = 2'd2
    } dmem_op_t;

    // Requester slots on the data-cache port
    localparam logic [sid_w-1:0] sid_ptw  = 1'b0;
    localparam logic [sid_w-1:0] sid_core = 1'b1;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        dmem_op_t          op;
        logic [be_w-1:0]   be;
        logic [size_w-1:0] size;
    } dmem_req_t;

    // PMU event map
    localparam int evt_ptw_req     = 0;
    localparam int evt_dmem_load   = 1;
    localparam int evt_dmem_store  = 2;
    localparam int evt_dmem_stall  = 3;
    localparam int evt_fill_beat   = 4;
    localparam int evt_fill_l2_hit = 5;
    localparam int pmu_num_events  = 6;
    localparam int pmu_idx_w       = $clog2(pmu_num_events);

endpackage

//--- hw/ptw_dmem_adapter.sv
// Page table walker to data-cache adapter
// Maps walker commands onto data-cache operations and registers the
// responses that come back on the walker slot
`timescale 1ns/10ps

module ptw_dmem_adapter (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         ptw_req_valid_i,
    input  logic                         ptw_req_ready_i,
    input  logic [tile_pkg::addr_w-1:0]  ptw_req_addr_i,
    input  logic [tile_pkg::data_w-1:0]  ptw_req_data_i,
    input  tile_pkg::ptw_cmd_t           ptw_req_cmd_i,
    input  logic [tile_pkg::size_w-1:0]  ptw_req_size_i,
    output tile_pkg::dmem_req_t          ptw_req_o,
    input  logic                         dmem_rsp_valid_i,
    input  logic [tile_pkg::data_w-1:0]  dmem_rsp_rdata_i,
    output logic                         ptw_resp_valid_o,
    output logic [tile_pkg::data_w-1:0]  ptw_resp_data_o
);
    import tile_pkg::*;

    logic is_amo;

    // AMO-OR writes the whole word, plain reads touch no byte
    assign is_amo          = (ptw_req_cmd_i == ptw_cmd_amo_or);
    assign ptw_req_o.addr  = ptw_req_addr_i;
    assign ptw_req_o.wdata = ptw_req_data_i;
    assign ptw_req_o.op    = is_amo ? dmem_op_amo_or : dmem_op_load;
    assign ptw_req_o.be    = is_amo ? {be_w{1'b1}} : {be_w{1'b0}};
    assign ptw_req_o.size  = ptw_req_size_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptw_resp_valid_o <= 1'b0;
        end else begin
            ptw_resp_valid_o <= dmem_rsp_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dmem_rsp_valid_i) begin
            ptw_resp_data_o <= dmem_rsp_rdata_i;
        end
    end

    // Walker keeps its command while the port stalls it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ptw_req_valid_i && !ptw_req_ready_i |=> ptw_req_valid_i && $stable(ptw_req_cmd_i));

endmodule

//--- hw/dmem_req_arbiter.sv
// Data-cache request arbiter
// Fixed priority merge of the walker and the core onto one request
// port, response routing by source id and access events
`timescale 1ns/10ps

module dmem_req_arbiter (
    input  logic                        ptw_req_valid_i,
    input  tile_pkg::dmem_req_t         ptw_req_i,
    output logic                        ptw_req_ready_o,
    input  logic                        core_req_valid_i,
    input  tile_pkg::dmem_req_t         core_req_i,
    output logic                        core_req_ready_o,
    output logic                        dmem_req_valid_o,
    input  logic                        dmem_req_ready_i,
    output tile_pkg::dmem_req_t         dmem_req_o,
    output logic [tile_pkg::sid_w-1:0]  dmem_req_sid_o,
    input  logic                        dmem_rsp_valid_i,
    input  logic [tile_pkg::sid_w-1:0]  dmem_rsp_sid_i,
    output logic                        ptw_rsp_valid_o,
    output logic                        core_rsp_valid_o,
    output logic                        evt_load_o,
    output logic                        evt_store_o,
    output logic                        evt_stall_o
);
    import tile_pkg::*;

    logic ptw_grant;
    logic core_grant;
    logic core_fire;

    //------------------------------------------------------------------
    // Request side
    //------------------------------------------------------------------

    // Walker always wins, the core only gets an idle walker slot
    assign ptw_grant  = ptw_req_valid_i;
    assign core_grant = core_req_valid_i & ~ptw_req_valid_i;

    assign dmem_req_valid_o = ptw_req_valid_i | core_req_valid_i;
    assign dmem_req_o       = ptw_grant ? ptw_req_i : core_req_i;
    assign dmem_req_sid_o   = ptw_grant ? sid_ptw : sid_core;

    assign ptw_req_ready_o  = dmem_req_ready_i & ptw_grant;
    assign core_req_ready_o = dmem_req_ready_i & core_grant;

    //------------------------------------------------------------------
    // Response routing and events
    //------------------------------------------------------------------

    assign ptw_rsp_valid_o  = dmem_rsp_valid_i & (dmem_rsp_sid_i == sid_ptw);
    assign core_rsp_valid_o = dmem_rsp_valid_i & (dmem_rsp_sid_i == sid_core);

    assign core_fire   = core_req_valid_i & core_req_ready_o;
    assign evt_load_o  = core_fire & (core_req_i.op == dmem_op_load);
    assign evt_store_o = core_fire & (core_req_i.op == dmem_op_store);

    // Someone waits on a busy port
    assign evt_stall_o = dmem_req_valid_o & ~dmem_req_ready_i;

endmodule

//--- hw/ifill_grant_adapter.sv
// Instruction refill grant adapter
// Registers L2 grant beats into the I-cache fill response, flags the
// last beat as acknowledge and forwards invalidations
`timescale 1ns/10ps

module ifill_grant_adapter (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               mem_grant_valid_i,
    input  logic [tile_pkg::line_w-1:0]        mem_grant_data_i,
    input  logic [tile_pkg::beat_w-1:0]        mem_grant_beat_i,
    input  logic                               mem_grant_inval_i,
    input  logic [tile_pkg::inval_addr_w-1:0]  mem_grant_inval_addr_i,
    input  logic                               l2_hit_i,
    output logic                               ifill_valid_o,
    output logic [tile_pkg::line_w-1:0]        ifill_data_o,
    output logic [tile_pkg::beat_w-1:0]        ifill_beat_o,
    output logic                               ifill_ack_o,
    output logic                               ifill_inval_valid_o,
    output logic [tile_pkg::inval_addr_w-1:0]  ifill_inval_paddr_o,
    output logic                               evt_l2_hit_o
);
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ifill_valid_o       <= 1'b0;
            ifill_ack_o         <= 1'b0;
            ifill_inval_valid_o <= 1'b0;
        end else begin
            ifill_valid_o       <= mem_grant_valid_i;
            // Last of four beats closes the refill
            ifill_ack_o         <= mem_grant_valid_i & (&mem_grant_beat_i);
            ifill_inval_valid_o <= mem_grant_inval_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_grant_valid_i) begin
            ifill_data_o <= mem_grant_data_i;
            ifill_beat_o <= mem_grant_beat_i;
        end
        if (mem_grant_inval_i) begin
            ifill_inval_paddr_o <= mem_grant_inval_addr_i;
        end
    end

    assign evt_l2_hit_o = ifill_ack_o & l2_hit_i;

    // Invalidation leaves with a known line address
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_grant_inval_i |=> !$isunknown(ifill_inval_paddr_o));

endmodule

//--- hw/pmu_event_counters.sv
// Tile performance counters
// One saturating counter per event with a registered read port
`timescale 1ns/10ps

module pmu_event_counters (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic [tile_pkg::pmu_num_events-1:0]   evt_i,
    input  logic                                  rd_en_i,
    input  logic [tile_pkg::pmu_idx_w-1:0]        rd_idx_i,
    output logic                                  rd_valid_o,
    output logic [tile_pkg::cnt_w-1:0]            rd_data_o
);
    import tile_pkg::*;

    logic [cnt_w-1:0] cnt_q [pmu_num_events];

    // Counters stick at all ones
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < pmu_num_events; i++) begin
            if (!rst_n_i) begin
                cnt_q[i] <= '0;
            end else if (evt_i[i] && (cnt_q[i] != {cnt_w{1'b1}})) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    //------------------------------------------------------------------
    // Read port
    //------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= (rd_idx_i < pmu_num_events) ? cnt_q[rd_idx_i] : '0;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_en_i |-> rd_idx_i < pmu_num_events);

endmodule

//--- hw/tile_mem_glue.sv
// Tile memory glue top level
// Walker and core share the data-cache port, L2 grants become I-cache
// fills, and the tile events feed the PMU counters
`timescale 1ns/10ps

module tile_mem_glue (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    // Core requester
    input  logic                               core_req_valid_i,
    input  logic [tile_pkg::addr_w-1:0]        core_req_addr_i,
    input  logic [tile_pkg::data_w-1:0]        core_req_wdata_i,
    input  tile_pkg::dmem_op_t                 core_req_op_i,
    input  logic [tile_pkg::be_w-1:0]          core_req_be_i,
    input  logic [tile_pkg::size_w-1:0]        core_req_size_i,
    output logic                               core_req_ready_o,
    output logic                               core_resp_valid_o,
    output logic [tile_pkg::data_w-1:0]        core_resp_data_o,
    // Page table walker
    input  logic                               ptw_req_valid_i,
    input  logic [tile_pkg::addr_w-1:0]        ptw_req_addr_i,
    input  logic [tile_pkg::data_w-1:0]        ptw_req_data_i,
    input  tile_pkg::ptw_cmd_t                 ptw_req_cmd_i,
    input  logic [tile_pkg::size_w-1:0]        ptw_req_size_i,
    output logic                               ptw_req_ready_o,
    output logic                               ptw_resp_valid_o,
    output logic [tile_pkg::data_w-1:0]        ptw_resp_data_o,
    // Data cache
    output logic                               dmem_req_valid_o,
    input  logic                               dmem_req_ready_i,
    output logic [tile_pkg::addr_w-1:0]        dmem_req_addr_o,
    output logic [tile_pkg::data_w-1:0]        dmem_req_wdata_o,
    output tile_pkg::dmem_op_t                 dmem_req_op_o,
    output logic [tile_pkg::be_w-1:0]          dmem_req_be_o,
    output logic [tile_pkg::size_w-1:0]        dmem_req_size_o,
    output logic [tile_pkg::sid_w-1:0]         dmem_req_sid_o,
    input  logic                               dmem_rsp_valid_i,
    input  logic [tile_pkg::sid_w-1:0]         dmem_rsp_sid_i,
    input  logic [tile_pkg::data_w-1:0]        dmem_rsp_rdata_i,
    // L2 refill grants
    input  logic                               mem_grant_valid_i,
    input  logic [tile_pkg::line_w-1:0]        mem_grant_data_i,
    input  logic [tile_pkg::beat_w-1:0]        mem_grant_beat_i,
    input  logic                               mem_grant_inval_i,
    input  logic [tile_pkg::inval_addr_w-1:0]  mem_grant_inval_addr_i,
    input  logic                               l2_hit_i,
    output logic                               ifill_valid_o,
    output logic [tile_pkg::line_w-1:0]        ifill_data_o,
    output logic [tile_pkg::beat_w-1:0]        ifill_beat_o,
    output logic                               ifill_ack_o,
    output logic                               ifill_inval_valid_o,
    output logic [tile_pkg::inval_addr_w-1:0]  ifill_inval_paddr_o,
    // PMU read port
    input  logic                               pmu_rd_en_i,
    input  logic [tile_pkg::pmu_idx_w-1:0]     pmu_rd_idx_i,
    output logic                               pmu_rd_valid_o,
    output logic [tile_pkg::cnt_w-1:0]         pmu_rd_data_o
);
    import tile_pkg::*;

    dmem_req_t                 ptw_req;
    dmem_req_t                 core_req;
    dmem_req_t                 dmem_req;
    logic                      ptw_rsp_valid;
    logic                      evt_load;
    logic                      evt_store;
    logic                      evt_stall;
    logic                      evt_l2_hit;
    logic [pmu_num_events-1:0] evt;

    assign core_req.addr  = core_req_addr_i;
    assign core_req.wdata = core_req_wdata_i;
    assign core_req.op    = core_req_op_i;
    assign core_req.be    = core_req_be_i;
    assign core_req.size  = core_req_size_i;

    ptw_dmem_adapter ptw_dmem_adapter_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .ptw_req_valid_i  (ptw_req_valid_i),
        .ptw_req_ready_i  (ptw_req_ready_o),
        .ptw_req_addr_i   (ptw_req_addr_i),
        .ptw_req_data_i   (ptw_req_data_i),
        .ptw_req_cmd_i    (ptw_req_cmd_i),
        .ptw_req_size_i   (ptw_req_size_i),
        .ptw_req_o        (ptw_req),
        .dmem_rsp_valid_i (ptw_rsp_valid),
        .dmem_rsp_rdata_i (dmem_rsp_rdata_i),
        .ptw_resp_valid_o (ptw_resp_valid_o),
        .ptw_resp_data_o  (ptw_resp_data_o)
    );

    dmem_req_arbiter dmem_req_arbiter_inst (
        .ptw_req_valid_i  (ptw_req_valid_i),
        .ptw_req_i        (ptw_req),
        .ptw_req_ready_o  (ptw_req_ready_o),
        .core_req_valid_i (core_req_valid_i),
        .core_req_i       (core_req),
        .core_req_ready_o (core_req_ready_o),
        .dmem_req_valid_o (dmem_req_valid_o),
        .dmem_req_ready_i (dmem_req_ready_i),
        .dmem_req_o       (dmem_req),
        .dmem_req_sid_o   (dmem_req_sid_o),
        .dmem_rsp_valid_i (dmem_rsp_valid_i),
        .dmem_rsp_sid_i   (dmem_rsp_sid_i),
        .ptw_rsp_valid_o  (ptw_rsp_valid),
        .core_rsp_valid_o (core_resp_valid_o),
        .evt_load_o       (evt_load),
        .evt_store_o      (evt_store),
        .evt_stall_o      (evt_stall)
    );

    assign dmem_req_addr_o  = dmem_req.addr;
    assign dmem_req_wdata_o = dmem_req.wdata;
    assign dmem_req_op_o    = dmem_req.op;
    assign dmem_req_be_o    = dmem_req.be;
    assign dmem_req_size_o  = dmem_req.size;

    // Core sees the cache data directly
    assign core_resp_data_o = dmem_rsp_rdata_i;

    ifill_grant_adapter ifill_grant_adapter_inst (
        .clk_i                  (clk_i),
        .rst_n_i                (rst_n_i),
        .mem_grant_valid_i      (mem_grant_valid_i),
        .mem_grant_data_i       (mem_grant_data_i),
        .mem_grant_beat_i       (mem_grant_beat_i),
        .mem_grant_inval_i      (mem_grant_inval_i),
        .mem_grant_inval_addr_i (mem_grant_inval_addr_i),
        .l2_hit_i               (l2_hit_i),
        .ifill_valid_o          (ifill_valid_o),
        .ifill_data_o           (ifill_data_o),
        .ifill_beat_o           (ifill_beat_o),
        .ifill_ack_o            (ifill_ack_o),
        .ifill_inval_valid_o    (ifill_inval_valid_o),
        .ifill_inval_paddr_o    (ifill_inval_paddr_o),
        .evt_l2_hit_o           (evt_l2_hit)
    );

    //------------------------------------------------------------------
    // PMU events
    //------------------------------------------------------------------

    assign evt[evt_ptw_req]     = ptw_req_valid_i & ptw_req_ready_o;
    assign evt[evt_dmem_load]   = evt_load;
    assign evt[evt_dmem_store]  = evt_store;
    assign evt[evt_dmem_stall]  = evt_stall;
    assign evt[evt_fill_beat]   = ifill_valid_o;
    assign evt[evt_fill_l2_hit] = evt_l2_hit;

    pmu_event_counters pmu_event_counters_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .evt_i      (evt),
        .rd_en_i    (pmu_rd_en_i),
        .rd_idx_i   (pmu_rd_idx_i),
        .rd_valid_o (pmu_rd_valid_o),
        .rd_data_o  (pmu_rd_data_o)
    );

endmodule

//--- verif/tb_tile_mem_glue.sv
// Testbench for the tile memory glue
// Random walker and core traffic against a cache model with random ready,
// L2 refill grants, and a final read-back of the PMU counters
`timescale 1ns/10ps

module tb_tile_mem_glue;
    import tile_pkg::*;

    localparam int traffic_cycles = 1000;
    localparam int drain_cycles   = 8;
    localparam int wait_limit     = 200;

    logic                      clk_i;
    logic                      rst_n_i;
    logic                      core_req_valid_i;
    logic [addr_w-1:0]         core_req_addr_i;
    logic [data_w-1:0]         core_req_wdata_i;
    dmem_op_t                  core_req_op_i;
    logic [be_w-1:0]           core_req_be_i;
    logic [size_w-1:0]         core_req_size_i;
    logic                      core_req_ready_o;
    logic                      core_resp_valid_o;
    logic [data_w-1:0]         core_resp_data_o;
    logic                      ptw_req_valid_i;
    logic [addr_w-1:0]         ptw_req_addr_i;
    logic [data_w-1:0]         ptw_req_data_i;
    ptw_cmd_t                  ptw_req_cmd_i;
    logic [size_w-1:0]         ptw_req_size_i;
    logic                      ptw_req_ready_o;
    logic                      ptw_resp_valid_o;
    logic [data_w-1:0]         ptw_resp_data_o;
    logic                      dmem_req_valid_o;
    logic                      dmem_req_ready_i;
    logic [addr_w-1:0]         dmem_req_addr_o;
    logic [data_w-1:0]         dmem_req_wdata_o;
    dmem_op_t                  dmem_req_op_o;
    logic [be_w-1:0]           dmem_req_be_o;
    logic [size_w-1:0]         dmem_req_size_o;
    logic [sid_w-1:0]          dmem_req_sid_o;
    logic                      dmem_rsp_valid_i;
    logic [sid_w-1:0]          dmem_rsp_sid_i;
    logic [data_w-1:0]         dmem_rsp_rdata_i;
    logic                      mem_grant_valid_i;
    logic [line_w-1:0]         mem_grant_data_i;
    logic [beat_w-1:0]         mem_grant_beat_i;
    logic                      mem_grant_inval_i;
    logic [inval_addr_w-1:0]   mem_grant_inval_addr_i;
    logic                      l2_hit_i;
    logic                      ifill_valid_o;
    logic [line_w-1:0]         ifill_data_o;
    logic [beat_w-1:0]         ifill_beat_o;
    logic                      ifill_ack_o;
    logic                      ifill_inval_valid_o;
    logic [inval_addr_w-1:0]   ifill_inval_paddr_o;
    logic                      pmu_rd_en_i;
    logic [pmu_idx_w-1:0]      pmu_rd_idx_i;
    logic                      pmu_rd_valid_o;
    logic [cnt_w-1:0]          pmu_rd_data_o;

    // Model and reference state
    logic [15:0]               lfsr_q;
    bit                        checking;
    bit                        ptw_fire_q;
    bit                        core_fire_q;
    logic [sid_w-1:0]          acc_sid_q;
    logic [addr_w-1:0]         acc_addr_q;
    logic                      rsp_pipe_v [2];
    logic [sid_w-1:0]          rsp_pipe_sid [2];
    logic [data_w-1:0]         rsp_pipe_data [2];
    logic                      prev_ptw_rsp;
    logic [data_w-1:0]         prev_rsp_data;
    logic                      prev_grant_v;
    logic [line_w-1:0]         prev_grant_data;
    logic [beat_w-1:0]         prev_grant_beat;
    logic                      prev_inval;
    logic [inval_addr_w-1:0]   prev_inval_addr;
    logic                      prev_rd_en;
    int unsigned               exp_cnt [pmu_num_events];
    int                        ptw_wait;
    int                        core_wait;
    logic [beat_w-1:0]         beat_cnt;

    tile_mem_glue tile_mem_glue_inst (.*);

    always #50 clk_i = ~clk_i;

    //----------------------------------------------------------------------
    // Random source and reference functions
    //----------------------------------------------------------------------

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic dmem_op_t expected_op(input ptw_cmd_t cmd);
        return (cmd == ptw_cmd_amo_or) ? dmem_op_amo_or : dmem_op_load;
    endfunction

    function automatic logic [be_w-1:0] expected_be(input ptw_cmd_t cmd);
        return (cmd == ptw_cmd_amo_or) ? {be_w{1'b1}} : {be_w{1'b0}};
    endfunction

    // Walker acceptance in bit 0 and core acceptance in bit 1
    function automatic logic [1:0] expected_accept(input logic ptw_v, input logic core_v,
                                                    input logic ready);
        return {core_v & ~ptw_v & ready, ptw_v & ready};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [line_w-1:0] got,
                            input logic [line_w-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0d ns: %s is %0h, expected %0h",
                               $time, name, got, exp));
        end
    endtask

    //----------------------------------------------------------------------
    // Comparing process at the falling edge
    //----------------------------------------------------------------------

    always @(negedge clk_i) begin
        logic [1:0] acc;
        logic       ack_exp;
        acc     = expected_accept(ptw_req_valid_i, core_req_valid_i, dmem_req_ready_i);
        ack_exp = prev_grant_v && (prev_grant_beat == 2'd3);
        if (checking) begin
            check_eq("dmem_req_valid_o", dmem_req_valid_o, ptw_req_valid_i | core_req_valid_i);
            check_eq("ptw_req_ready_o", ptw_req_ready_o, acc[0]);
            check_eq("core_req_ready_o", core_req_ready_o, acc[1]);
            if (ptw_req_valid_i) begin
                check_eq("dmem_req_sid_o", dmem_req_sid_o, sid_ptw);
                check_eq("dmem_req_addr_o", dmem_req_addr_o, ptw_req_addr_i);
                check_eq("dmem_req_wdata_o", dmem_req_wdata_o, ptw_req_data_i);
                check_eq("dmem_req_op_o", dmem_req_op_o, expected_op(ptw_req_cmd_i));
                check_eq("dmem_req_be_o", dmem_req_be_o, expected_be(ptw_req_cmd_i));
                check_eq("dmem_req_size_o", dmem_req_size_o, ptw_req_size_i);
            end else if (core_req_valid_i) begin
                check_eq("dmem_req_sid_o", dmem_req_sid_o, sid_core);
                check_eq("dmem_req_addr_o", dmem_req_addr_o, core_req_addr_i);
                check_eq("dmem_req_wdata_o", dmem_req_wdata_o, core_req_wdata_i);
                check_eq("dmem_req_op_o", dmem_req_op_o, core_req_op_i);
                check_eq("dmem_req_be_o", dmem_req_be_o, core_req_be_i);
                check_eq("dmem_req_size_o", dmem_req_size_o, core_req_size_i);
            end
            check_eq("core_resp_valid_o", core_resp_valid_o,
                     dmem_rsp_valid_i && (dmem_rsp_sid_i == sid_core));
            if (core_resp_valid_o) begin
                check_eq("core_resp_data_o", core_resp_data_o, dmem_rsp_rdata_i);
            end
            check_eq("ptw_resp_valid_o", ptw_resp_valid_o, prev_ptw_rsp);
            if (prev_ptw_rsp) begin
                check_eq("ptw_resp_data_o", ptw_resp_data_o, prev_rsp_data);
            end
            check_eq("ifill_valid_o", ifill_valid_o, prev_grant_v);
            if (prev_grant_v) begin
                check_eq("ifill_data_o", ifill_data_o, prev_grant_data);
                check_eq("ifill_beat_o", ifill_beat_o, prev_grant_beat);
            end
            check_eq("ifill_ack_o", ifill_ack_o, ack_exp);
            check_eq("ifill_inval_valid_o", ifill_inval_valid_o, prev_inval);
            if (prev_inval) begin
                check_eq("ifill_inval_paddr_o", ifill_inval_paddr_o, prev_inval_addr);
            end
            check_eq("pmu_rd_valid_o", pmu_rd_valid_o, prev_rd_en);
            exp_cnt[evt_ptw_req]     += int'(acc[0]);
            exp_cnt[evt_dmem_load]   += int'(acc[1] && core_req_op_i == dmem_op_load);
            exp_cnt[evt_dmem_store]  += int'(acc[1] && core_req_op_i == dmem_op_store);
            exp_cnt[evt_dmem_stall]  += int'((ptw_req_valid_i || core_req_valid_i)
                                             && !dmem_req_ready_i);
            exp_cnt[evt_fill_beat]   += int'(prev_grant_v);
            exp_cnt[evt_fill_l2_hit] += int'(ack_exp && l2_hit_i);
        end
        // Handshake results for the requester and cache models
        ptw_fire_q      = acc[0];
        core_fire_q     = acc[1];
        acc_sid_q       = acc[0] ? sid_ptw : sid_core;
        acc_addr_q      = acc[0] ? ptw_req_addr_i : core_req_addr_i;
        prev_ptw_rsp    = dmem_rsp_valid_i && (dmem_rsp_sid_i == sid_ptw);
        prev_rsp_data   = dmem_rsp_rdata_i;
        prev_grant_v    = mem_grant_valid_i;
        prev_grant_data = mem_grant_data_i;
        prev_grant_beat = mem_grant_beat_i;
        prev_inval      = mem_grant_inval_i;
        prev_inval_addr = mem_grant_inval_addr_i;
        prev_rd_en      = pmu_rd_en_i;
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------

    task automatic drive_cycle(input bit traffic);
        logic [1:0] op_sel;
        @(posedge clk_i);
        #1;
        // Cache answers two cycles after acceptance with the address as data
        dmem_rsp_valid_i = rsp_pipe_v[1];
        dmem_rsp_sid_i   = rsp_pipe_sid[1];
        dmem_rsp_rdata_i = rsp_pipe_data[1];
        rsp_pipe_v[1]    = rsp_pipe_v[0];
        rsp_pipe_sid[1]  = rsp_pipe_sid[0];
        rsp_pipe_data[1] = rsp_pipe_data[0];
        rsp_pipe_v[0]    = ptw_fire_q | core_fire_q;
        rsp_pipe_sid[0]  = acc_sid_q;
        rsp_pipe_data[0] = {{(data_w - addr_w){1'b0}}, acc_addr_q};
        dmem_req_ready_i = traffic ? (rand_bits(2) != 0) : 1'b1;

        if (ptw_fire_q || !ptw_req_valid_i) begin
            ptw_req_valid_i = traffic && (rand_bits(2) == 0);
            ptw_req_addr_i  = rand_bits(addr_w);
            ptw_req_data_i  = rand_bits(data_w);
            ptw_req_cmd_i   = rand_bits(1) ? ptw_cmd_amo_or : ptw_cmd_t'(rand_bits(5));
            ptw_req_size_i  = rand_bits(size_w);
            ptw_wait        = 0;
        end else begin
            ptw_wait++;
            if (ptw_wait > wait_limit) begin
                fail_run("Timeout: walker request was never accepted");
            end
        end

        if (core_fire_q || !core_req_valid_i) begin
            op_sel           = rand_bits(2);
            core_req_valid_i = traffic && rand_bits(1);
            core_req_addr_i  = rand_bits(addr_w);
            core_req_wdata_i = rand_bits(data_w);
            core_req_op_i    = (op_sel == 2'd3) ? dmem_op_amo_or :
                               (op_sel[1] ? dmem_op_store : dmem_op_load);
            core_req_be_i    = rand_bits(be_w);
            core_req_size_i  = rand_bits(size_w);
            core_wait        = 0;
        end else begin
            core_wait++;
            if (core_wait > wait_limit) begin
                fail_run("Timeout: core request was never accepted");
            end
        end

        mem_grant_valid_i      = traffic && rand_bits(1);
        mem_grant_data_i       = {rand_bits(64), rand_bits(64), rand_bits(64), rand_bits(64)};
        mem_grant_beat_i       = beat_cnt;
        mem_grant_inval_i      = traffic && (rand_bits(3) == 0);
        mem_grant_inval_addr_i = rand_bits(inval_addr_w);
        l2_hit_i               = rand_bits(1);
        if (mem_grant_valid_i) begin
            beat_cnt++;
        end
    endtask

    task automatic read_counter(input int idx);
        int waited;
        @(posedge clk_i);
        #1;
        pmu_rd_en_i  = 1'b1;
        pmu_rd_idx_i = idx[pmu_idx_w-1:0];
        @(posedge clk_i);
        #1;
        pmu_rd_en_i  = 1'b0;
        pmu_rd_idx_i = '0;
        waited = 0;
        do begin
            @(negedge clk_i);
            waited++;
            if (waited > 10) begin
                fail_run("Timeout: PMU read returned no valid strobe");
            end
        end while (!pmu_rd_valid_o);
        check_eq($sformatf("pmu_rd_data_o[%0d]", idx), pmu_rd_data_o, exp_cnt[idx]);
    endtask

    initial begin
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        lfsr_q = 16'd94;
        checking = 1'b0;
        {core_req_valid_i, core_req_addr_i, core_req_wdata_i} = '0;
        {core_req_be_i, core_req_size_i} = '0;
        core_req_op_i = dmem_op_load;
        {ptw_req_valid_i, ptw_req_addr_i, ptw_req_data_i, ptw_req_cmd_i, ptw_req_size_i} = '0;
        {dmem_req_ready_i, dmem_rsp_valid_i, dmem_rsp_sid_i, dmem_rsp_rdata_i} = '0;
        {mem_grant_valid_i, mem_grant_data_i, mem_grant_beat_i} = '0;
        {mem_grant_inval_i, mem_grant_inval_addr_i, l2_hit_i} = '0;
        {pmu_rd_en_i, pmu_rd_idx_i} = '0;
        rsp_pipe_v = '{default: 1'b0};
        rsp_pipe_sid = '{default: '0};
        rsp_pipe_data = '{default: '0};
        exp_cnt = '{default: 0};
        {ptw_fire_q, core_fire_q, acc_sid_q, acc_addr_q} = '0;
        {ptw_wait, core_wait, beat_cnt} = '0;

        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i  = 1'b1;
        checking = 1'b1;

        // Counters start from zero
        for (int i = 0; i < pmu_num_events; i++) begin
            read_counter(i);
        end
        for (int c = 0; c < traffic_cycles; c++) begin
            drive_cycle(1'b1);
        end
        // Let pending requests, responses and fill events settle
        for (int c = 0; c < drain_cycles; c++) begin
            drive_cycle(1'b0);
        end
        for (int i = 0; i < pmu_num_events; i++) begin
            read_counter(i);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

//--- sources.f
hw/tile_pkg.sv
hw/ptw_dmem_adapter.sv
hw/dmem_req_arbiter.sv
hw/ifill_grant_adapter.sv
hw/pmu_event_counters.sv
hw/tile_mem_glue.sv
verif/tb_tile_mem_glue.sv

//--- Makefile
# Verilator build and run for the tile memory glue testbench

VERILATOR ?= verilator
TOP       ?= tb_tile_mem_glue
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
